//--- core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Core geometry
`define CORE_THREADS       4        // Hardware threads
`define CORE_REGS          16       // Registers per thread
`define CORE_XLEN          32       // Data and address width

// Start addresses, thread n starts at RESET_PC + n * STRIDE
`define CORE_RESET_PC      32'h0
`define CORE_THREAD_STRIDE 32'h400

// Issue, retire, taken branch, I/O access
`define CORE_PERF_EVENTS   4

`endif

//--- core_pkg.sv
`include "core_cfg.svh"

package core_pkg;
    typedef logic [$clog2(`CORE_THREADS)-1:0] thread_idx_t;
    typedef logic [`CORE_THREADS-1:0]         thread_bitmap_t;  // One bit per thread
    typedef logic [$clog2(`CORE_REGS)-1:0]    reg_idx_t;
    typedef logic [`CORE_XLEN-1:0]            word_t;

    // Instruction word layout
    //   [31:28] opcode, [27:24] rd, [23:20] ra, [19:16] rb, [15:0] immediate
    // The immediate is sign-extended except for LUI, which puts it in the upper half.
    // Codes not listed here retire as a no-op.
    typedef enum logic [3:0] {
        OP_ADD   = 4'h0,
        OP_SUB   = 4'h1,
        OP_AND   = 4'h2,
        OP_OR    = 4'h3,
        OP_XOR   = 4'h4,
        OP_SHL   = 4'h5,    // ra << rb[4:0]
        OP_SHR   = 4'h6,    // Logical right shift
        OP_ADDI  = 4'h7,
        OP_LUI   = 4'h8,
        OP_BEQZ  = 4'h9,    // Branch if ra == 0
        OP_JUMP  = 4'ha,
        OP_LOAD  = 4'hb,    // rd = io[ra + imm]
        OP_STORE = 4'hc,    // io[ra + imm] = rb
        OP_HALT  = 4'hd
    } opcode_t;

    typedef enum logic [1:0] {
        IDLE,               // Buffer empty, may fetch
        FETCH,              // On the bus or holding a word
        WAIT_RETIRE,        // Issued, result pending
        HALTED
    } fetch_state_t;

    // Round robin pick, first requester after last, last itself comes last
    function automatic thread_idx_t rr_next(input thread_bitmap_t req, input thread_idx_t last);
        thread_idx_t cand;
        thread_idx_t pick;

        pick = last;
        for (int i = `CORE_THREADS; i >= 1; i--) begin
            cand = last + thread_idx_t'(i);     // Wraps at thread count
            if (req[cand])
                pick = cand;                    // Nearest one wins
        end
        return pick;
    endfunction
endpackage

//--- ifetch_unit.sv
`include "core_cfg.svh"

module ifetch_unit import core_pkg::*; (
    input                  clk,
    input                  arst_n,
    input thread_bitmap_t  thread_en,

    // Wishbone instruction bus
    output logic           ibus_cyc,
    output logic           ibus_stb,
    output word_t          ibus_adr,
    input word_t           ibus_rdat,
    input                  ibus_ack,

    // From thread_select_stage
    input                  issue_en,
    input thread_idx_t     issue_thread,

    // From int_execute_stage
    input                  retire_en,
    input thread_idx_t     retire_thread,
    input word_t           next_pc,
    input                  halt,

    // From io_request_queue
    input                  io_done,
    input thread_idx_t     io_thread,

    // To thread_select_stage
    output thread_bitmap_t buf_ready,
    output word_t          buf_instr [`CORE_THREADS],
    output word_t          buf_pc [`CORE_THREADS]
);
    fetch_state_t   state [`CORE_THREADS];
    word_t          pc [`CORE_THREADS];
    thread_bitmap_t fetch_req;
    thread_idx_t    fetch_thread;       // Thread on the bus, also RR pointer
    thread_idx_t    fetch_pick;
    logic           fetch_start;
    logic           fetch_done;

    always_comb begin
        for (int t = 0; t < `CORE_THREADS; t++)
            fetch_req[t] = (state[t] == IDLE) && thread_en[t];  // Disabled never fetches
    end

    assign fetch_pick  = rr_next(fetch_req, fetch_thread);
    assign fetch_start = !ibus_cyc && (|fetch_req);     // Bus idle, someone waiting
    assign fetch_done  = ibus_cyc && ibus_ack;
    assign buf_pc      = pc;                            // PC holds until retire

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ibus_cyc     <= 1'b0;
            ibus_stb     <= 1'b0;
            fetch_thread <= '0;
            buf_ready    <= '0;
            for (int t = 0; t < `CORE_THREADS; t++) begin
                state[t] <= IDLE;
                pc[t]    <= `CORE_RESET_PC + word_t'(t) * `CORE_THREAD_STRIDE;
            end
        end else begin
            if (fetch_start) begin
                ibus_cyc     <= 1'b1;
                ibus_stb     <= 1'b1;
                fetch_thread <= fetch_pick;
            end else if (fetch_done) begin
                ibus_cyc                <= 1'b0;    // Drop after ack
                ibus_stb                <= 1'b0;
                buf_ready[fetch_thread] <= 1'b1;
            end
            if (issue_en)
                buf_ready[issue_thread] <= 1'b0;    // Buffer consumed

            for (int t = 0; t < `CORE_THREADS; t++) begin
                case (state[t])
                    IDLE: if (fetch_start && fetch_pick == thread_idx_t'(t))
                        state[t] <= FETCH;
                    FETCH: if (issue_en && issue_thread == thread_idx_t'(t))
                        state[t] <= WAIT_RETIRE;
                    WAIT_RETIRE: begin
                        if (retire_en && retire_thread == thread_idx_t'(t)) begin
                            pc[t]    <= next_pc;
                            state[t] <= halt ? HALTED : IDLE;
                        end else if (io_done && io_thread == thread_idx_t'(t)) begin
                            pc[t]    <= pc[t] + word_t'(4);    // I/O never branches
                            state[t] <= IDLE;
                        end
                    end
                    default: ;                      // HALTED for good
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_start)
            ibus_adr <= pc[fetch_pick];             // Stable until ack
        if (fetch_done)
            buf_instr[fetch_thread] <= ibus_rdat;
    end
endmodule

//--- thread_select_stage.sv
`include "core_cfg.svh"

module thread_select_stage import core_pkg::*; (
    input                  clk,
    input                  arst_n,

    // From ifetch_unit
    input thread_bitmap_t  buf_ready,
    input word_t           buf_instr [`CORE_THREADS],
    input word_t           buf_pc [`CORE_THREADS],

    // Back to ifetch_unit
    output logic           issue_en,
    output thread_idx_t    issue_thread,

    // To operand_fetch_stage
    output logic           ts_valid,
    output thread_idx_t    ts_thread,
    output word_t          ts_pc,
    output opcode_t        ts_op,
    output reg_idx_t       ts_rd,
    output reg_idx_t       ts_ra,
    output reg_idx_t       ts_rb,
    output word_t          ts_imm
);
    thread_idx_t last_issue;            // RR pointer
    word_t       instr;
    opcode_t     op;
    word_t       imm;

    assign issue_en     = |buf_ready;   // Never stalls
    assign issue_thread = rr_next(buf_ready, last_issue);
    assign instr        = buf_instr[issue_thread];
    assign op           = opcode_t'(instr[31:28]);

    // LUI goes to the upper half, everything else sign-extends
    assign imm = (op == OP_LUI) ? {instr[15:0], 16'h0000}
                                : {{16{instr[15]}}, instr[15:0]};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ts_valid   <= 1'b0;
            last_issue <= '0;
        end else begin
            ts_valid <= issue_en;
            if (issue_en)
                last_issue <= issue_thread;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_en) begin
            ts_thread <= issue_thread;
            ts_pc     <= buf_pc[issue_thread];
            ts_op     <= op;
            ts_rd     <= instr[27:24];
            ts_ra     <= instr[23:20];
            ts_rb     <= instr[19:16];
            ts_imm    <= imm;
        end
    end
endmodule

//--- operand_fetch_stage.sv
`include "core_cfg.svh"

module operand_fetch_stage import core_pkg::*; (
    input                  clk,
    input                  arst_n,

    // From thread_select_stage
    input                  ts_valid,
    input thread_idx_t     ts_thread,
    input word_t           ts_pc,
    input opcode_t         ts_op,
    input reg_idx_t        ts_rd,
    input reg_idx_t        ts_ra,
    input reg_idx_t        ts_rb,
    input word_t           ts_imm,

    // Write port A, integer results
    input                  wa_en,
    input thread_idx_t     wa_thread,
    input reg_idx_t        wa_reg,
    input word_t           wa_data,

    // Write port B, load data
    input                  wb_en,
    input thread_idx_t     wb_thread,
    input reg_idx_t        wb_reg,
    input word_t           wb_data,

    // To int_execute_stage
    output logic           of_valid,
    output thread_idx_t    of_thread,
    output word_t          of_pc,
    output opcode_t        of_op,
    output reg_idx_t       of_rd,
    output word_t          of_imm,
    output word_t          of_opa,
    output word_t          of_opb
);
    word_t regs [`CORE_THREADS][`CORE_REGS];    // One file per thread

    always_ff @(posedge clk) begin
        if (wa_en)
            regs[wa_thread][wa_reg] <= wa_data;
        if (wb_en)
            regs[wb_thread][wb_reg] <= wb_data;     // Other thread than port A
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            of_valid <= 1'b0;
        else
            of_valid <= ts_valid;
    end

    // Thread's previous result is already written, no bypass
    always_ff @(posedge clk) begin
        of_thread <= ts_thread;
        of_pc     <= ts_pc;
        of_op     <= ts_op;
        of_rd     <= ts_rd;
        of_imm    <= ts_imm;
        of_opa    <= regs[ts_thread][ts_ra];
        of_opb    <= regs[ts_thread][ts_rb];
    end
endmodule

//--- int_execute_stage.sv
module int_execute_stage import core_pkg::*; (
    input                  clk,
    input                  arst_n,

    // From operand_fetch_stage
    input                  of_valid,
    input thread_idx_t     of_thread,
    input word_t           of_pc,
    input opcode_t         of_op,
    input reg_idx_t        of_rd,
    input word_t           of_imm,
    input word_t           of_opa,
    input word_t           of_opb,

    // Register file write port A
    output logic           wa_en,
    output thread_idx_t    wa_thread,
    output reg_idx_t       wa_reg,
    output word_t          wa_data,

    // Retirement to ifetch_unit
    output logic           retire_en,
    output thread_idx_t    retire_thread,
    output word_t          next_pc,
    output logic           halt,
    output logic           branch_taken,

    // To io_request_queue
    output logic           io_req,
    output thread_idx_t    io_req_thread,
    output logic           io_req_we,
    output word_t          io_req_adr,
    output word_t          io_req_wdat,
    output reg_idx_t       io_req_rd
);
    word_t result;
    logic  writes;
    logic  is_io;
    logic  taken;
    word_t seq_pc;
    word_t target;

    assign writes = of_op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR,
                                  OP_SHL, OP_SHR, OP_ADDI, OP_LUI};
    assign is_io  = of_op inside {OP_LOAD, OP_STORE};
    assign taken  = (of_op == OP_JUMP) || (of_op == OP_BEQZ && of_opa == '0);
    assign seq_pc = of_pc + word_t'(4);
    assign target = seq_pc + (of_imm << 2);     // Word offset from next PC

    always_comb begin
        case (of_op)
            OP_ADD:  result = of_opa + of_opb;
            OP_SUB:  result = of_opa - of_opb;
            OP_AND:  result = of_opa & of_opb;
            OP_OR:   result = of_opa | of_opb;
            OP_XOR:  result = of_opa ^ of_opb;
            OP_SHL:  result = of_opa << of_opb[4:0];
            OP_SHR:  result = of_opa >> of_opb[4:0];    // Logical
            OP_ADDI: result = of_opa + of_imm;
            OP_LUI:  result = of_imm;                   // Already shifted up
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wa_en        <= 1'b0;
            retire_en    <= 1'b0;
            branch_taken <= 1'b0;
            io_req       <= 1'b0;
        end else begin
            wa_en        <= of_valid && writes;
            retire_en    <= of_valid && !is_io;     // I/O retires on io_done
            branch_taken <= of_valid && taken;
            io_req       <= of_valid && is_io;
        end
    end

    always_ff @(posedge clk) begin
        wa_thread     <= of_thread;
        wa_reg        <= of_rd;
        wa_data       <= result;
        retire_thread <= of_thread;
        next_pc       <= taken ? target : seq_pc;
        halt          <= (of_op == OP_HALT);
        io_req_thread <= of_thread;
        io_req_we     <= (of_op == OP_STORE);
        io_req_adr    <= of_opa + of_imm;
        io_req_wdat   <= of_opb;                // rb is store data
        io_req_rd     <= of_rd;
    end
endmodule

//--- io_request_queue.sv
`include "core_cfg.svh"

module io_request_queue import core_pkg::*; (
    input                  clk,
    input                  arst_n,

    // From int_execute_stage
    input                  io_req,
    input thread_idx_t     io_req_thread,
    input                  io_req_we,
    input word_t           io_req_adr,
    input word_t           io_req_wdat,
    input reg_idx_t        io_req_rd,

    // Wishbone data bus
    output logic           dbus_cyc,
    output logic           dbus_stb,
    output logic           dbus_we,
    output word_t          dbus_adr,
    output word_t          dbus_wdat,
    input word_t           dbus_rdat,
    input                  dbus_ack,

    // Register file write port B
    output logic           wb_en,
    output thread_idx_t    wb_thread,
    output reg_idx_t       wb_reg,
    output word_t          wb_data,

    // Completion to ifetch_unit
    output logic           io_done,
    output thread_idx_t    io_thread
);
    thread_bitmap_t slot_valid;         // One pending access per thread
    logic           slot_we [`CORE_THREADS];
    word_t          slot_adr [`CORE_THREADS];
    word_t          slot_wdat [`CORE_THREADS];
    reg_idx_t       slot_rd [`CORE_THREADS];
    thread_idx_t    cur;                // Slot on the bus, also RR pointer
    thread_idx_t    pick;
    logic           start;
    logic           done;

    assign pick  = rr_next(slot_valid, cur);
    assign start = !dbus_cyc && (|slot_valid);
    assign done  = dbus_cyc && dbus_ack;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dbus_cyc   <= 1'b0;
            dbus_stb   <= 1'b0;
            dbus_we    <= 1'b0;
            cur        <= '0;
            slot_valid <= '0;
            wb_en      <= 1'b0;
            io_done    <= 1'b0;
        end else begin
            wb_en   <= done && !dbus_we;        // Loads only
            io_done <= done;
            if (done) begin
                dbus_cyc        <= 1'b0;
                dbus_stb        <= 1'b0;
                dbus_we         <= 1'b0;
                slot_valid[cur] <= 1'b0;
            end else if (start) begin
                dbus_cyc <= 1'b1;
                dbus_stb <= 1'b1;
                dbus_we  <= slot_we[pick];
                cur      <= pick;
            end
            if (io_req)
                slot_valid[io_req_thread] <= 1'b1;  // Never the slot being freed
        end
    end

    always_ff @(posedge clk) begin
        if (io_req) begin
            slot_we[io_req_thread]   <= io_req_we;
            slot_adr[io_req_thread]  <= io_req_adr;
            slot_wdat[io_req_thread] <= io_req_wdat;
            slot_rd[io_req_thread]   <= io_req_rd;
        end
        if (start) begin
            dbus_adr  <= slot_adr[pick];        // Held until ack
            dbus_wdat <= slot_wdat[pick];
        end
        if (done) begin
            wb_thread <= cur;
            wb_reg    <= slot_rd[cur];
            wb_data   <= dbus_rdat;
            io_thread <= cur;
        end
    end
endmodule

//--- core.sv
`include "core_cfg.svh"

module core import core_pkg::*; (
    input                                clk,
    input                                arst_n,
    input thread_bitmap_t                thread_en,

    // Wishbone instruction bus
    output logic                         ibus_cyc,
    output logic                         ibus_stb,
    output word_t                        ibus_adr,
    input word_t                         ibus_rdat,
    input                                ibus_ack,

    // Wishbone data bus
    output logic                         dbus_cyc,
    output logic                         dbus_stb,
    output logic                         dbus_we,
    output word_t                        dbus_adr,
    output word_t                        dbus_wdat,
    input word_t                         dbus_rdat,
    input                                dbus_ack,

    output logic [`CORE_PERF_EVENTS-1:0] perf_events
);
    // Fetch and select
    logic           issue_en;
    thread_idx_t    issue_thread;
    thread_bitmap_t buf_ready;
    word_t          buf_instr [`CORE_THREADS];
    word_t          buf_pc [`CORE_THREADS];

    // Select to operand fetch
    logic           ts_valid;
    thread_idx_t    ts_thread;
    word_t          ts_pc;
    opcode_t        ts_op;
    reg_idx_t       ts_rd;
    reg_idx_t       ts_ra;
    reg_idx_t       ts_rb;
    word_t          ts_imm;

    // Operand fetch to execute
    logic           of_valid;
    thread_idx_t    of_thread;
    word_t          of_pc;
    opcode_t        of_op;
    reg_idx_t       of_rd;
    word_t          of_imm;
    word_t          of_opa;
    word_t          of_opb;

    // Register file write ports
    logic           wa_en;
    thread_idx_t    wa_thread;
    reg_idx_t       wa_reg;
    word_t          wa_data;
    logic           wb_en;
    thread_idx_t    wb_thread;
    reg_idx_t       wb_reg;
    word_t          wb_data;

    // Retirement and I/O
    logic           retire_en;
    thread_idx_t    retire_thread;
    word_t          next_pc;
    logic           halt;
    logic           branch_taken;
    logic           io_req;
    thread_idx_t    io_req_thread;
    logic           io_req_we;
    word_t          io_req_adr;
    word_t          io_req_wdat;
    reg_idx_t       io_req_rd;
    logic           io_done;
    thread_idx_t    io_thread;

    ifetch_unit         ifetch_unit(.*);
    thread_select_stage thread_select_stage(.*);
    operand_fetch_stage operand_fetch_stage(.*);
    int_execute_stage   int_execute_stage(.*);
    io_request_queue    io_request_queue(.*);

    // Bit count must match CORE_PERF_EVENTS
    assign perf_events = {
        io_done,                    // I/O access done
        branch_taken,               // Taken branch or jump
        retire_en | io_done,        // Integer or I/O retire
        ts_valid                    // Issue
    };
endmodule

//--- core_properties.sv
module core_properties (
    input        clk,
    input        arst_n,
    input        dbus_cyc,
    input        dbus_stb,
    input        dbus_we,
    input [31:0] dbus_adr,
    input [31:0] dbus_wdat,
    input        dbus_ack,
    input        wb_en
);
    timeunit 1ns;
    timeprecision 100ps;

    stb_needs_cyc: assert property (@(posedge clk) disable iff (!arst_n)
        dbus_stb |-> dbus_cyc)
        else $error("dbus stb without cyc");

    // Request fields frozen while waiting
    req_stable: assert property (@(posedge clk) disable iff (!arst_n)
        dbus_cyc && dbus_stb && !dbus_ack |=>
            $stable(dbus_adr) && $stable(dbus_wdat) && $stable(dbus_we))
        else $error("dbus request changed before ack");

    wb_single: assert property (@(posedge clk) disable iff (!arst_n)
        wb_en |=> !wb_en)
        else $error("port B strobed twice for one ack");
endmodule

bind io_request_queue core_properties props (
    .clk       (clk),
    .arst_n    (arst_n),
    .dbus_cyc  (dbus_cyc),
    .dbus_stb  (dbus_stb),
    .dbus_we   (dbus_we),
    .dbus_adr  (dbus_adr),
    .dbus_wdat (dbus_wdat),
    .dbus_ack  (dbus_ack),
    .wb_en     (wb_en)
);

//--- core_tb.sv
`include "core_cfg.svh"

module core_tb import core_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    logic        clk;
    logic        arst_n;
    logic [3:0]  thread_en;
    logic        ibus_cyc, ibus_stb, ibus_ack;
    logic [31:0] ibus_adr, ibus_rdat;
    logic        dbus_cyc, dbus_stb, dbus_we, dbus_ack;
    logic [31:0] dbus_adr, dbus_wdat, dbus_rdat;
    logic [3:0]  perf_events;

    logic [31:0] imem [4096];           // 16 KB code space
    logic [31:0] dmem [1024];           // 4 KB I/O space
    logic [31:0] wr_log [$];            // Addresses of every write
    logic [31:0] lcg_state;
    logic        rand_wait;
    int          ibusy, iwait, dbusy, dwait;
    int          err_value, err_other;
    int          n_issue, n_retire, n_dual, n_branch, n_io;
    logic [3:0]  halted;

    core DUT(.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 8;
    endfunction

    function automatic logic [31:0] enc(opcode_t op, int rd, int ra, int rb, int imm);
        return {op, rd[3:0], ra[3:0], rb[3:0], imm[15:0]};
    endfunction

    // Reference ALU from the instruction semantics
    function automatic logic [31:0] alu_ref(opcode_t op, logic [31:0] a, logic [31:0] b);
        case (op)
            OP_ADD:  return a + b;
            OP_SUB:  return a - b;
            OP_AND:  return a & b;
            OP_OR:   return a | b;
            OP_XOR:  return a ^ b;
            OP_SHL:  return a << b[4:0];
            default: return a >> b[4:0];
        endcase
    endfunction

    task automatic clear_mem();
        for (int i = 0; i < 4096; i++)
            imem[i] = 32'hd000_0000 | (i << 2);     // HALT, tagged by address
        for (int i = 0; i < 1024; i++)
            dmem[i] = 32'hdada_0000 ^ (i << 2);
        wr_log.delete();
    endtask

    task automatic put(int t, int idx, logic [31:0] w);
        imem[t * (`CORE_THREAD_STRIDE / 4) + idx] = w;
    endtask

    task automatic check_word(logic [31:0] adr, logic [31:0] exp, string what);
        if (dmem[adr[11:2]] !== exp) begin
            $display("[ERROR] %0t: %s at %h is %h, expected %h",
                     $time, what, adr, dmem[adr[11:2]], exp);
            err_value++;
        end
    endtask

    task automatic check_count(int got, int exp, string what);
        if (got != exp) begin
            $display("[ERROR] %0t: %s count %0d, expected %0d", $time, what, got, exp);
            err_value++;
        end
    endtask

    // Instruction bus model, random wait states
    always @(posedge clk) begin
        #2;
        if (!arst_n || ibus_ack) begin
            ibus_ack = 1'b0;
            ibusy    = 0;
        end else if (ibus_cyc && ibus_stb) begin
            if (!ibusy) begin
                ibusy = 1;
                iwait = rand_wait ? lcg_next() % 4 : 0;
                if (!thread_en[ibus_adr[11:10]]) begin
                    $display("Fetch at %h from the code of disabled thread %0d",
                             ibus_adr, ibus_adr[11:10]);
                    err_other++;
                end
            end
            if (iwait == 0) begin
                ibus_rdat = imem[ibus_adr[13:2]];
                ibus_ack  = 1'b1;
            end else begin
                iwait--;
            end
        end
    end

    // Data bus model, logs every write
    always @(posedge clk) begin
        #2;
        if (!arst_n || dbus_ack) begin
            dbus_ack = 1'b0;
            dbusy    = 0;
        end else if (dbus_cyc && dbus_stb) begin
            if (!dbusy) begin
                dbusy = 1;
                dwait = rand_wait ? lcg_next() % 4 : 0;
            end
            if (dwait == 0) begin
                if (dbus_we) begin
                    dmem[dbus_adr[11:2]] = dbus_wdat;
                    wr_log.push_back(dbus_adr);
                end
                dbus_rdat = dmem[dbus_adr[11:2]];
                dbus_ack  = 1'b1;
            end else begin
                dwait--;
            end
        end
    end

    // Event counters, sampled away from the active edge
    always @(negedge clk) begin
        if (arst_n) begin
            n_issue  += perf_events[0];
            n_retire += perf_events[1];
            n_branch += perf_events[2];
            n_io     += perf_events[3];
            n_dual   += DUT.retire_en && DUT.io_done;    // Two retires, one pulse
            if (DUT.retire_en && DUT.halt)
                halted[DUT.retire_thread] = 1'b1;
        end
    end

    task automatic run_program(logic [3:0] en, int limit);
        int cyc;
        arst_n    = 1'b0;
        thread_en = 4'h0;
        n_issue   = 0;
        n_retire  = 0;
        n_dual    = 0;
        n_branch  = 0;
        n_io      = 0;
        halted    = 4'h0;
        repeat (4) @(posedge clk);
        #2 arst_n = 1'b1;
        @(posedge clk);
        #2 thread_en = en;
        for (cyc = 0; cyc < limit && (halted & en) != en; cyc++)
            @(posedge clk);
        if ((halted & en) != en) begin
            $display("Timeout: threads %b did not halt, halted %b", en, halted);
            err_other++;
        end
        repeat (2) @(posedge clk);
        check_count(n_retire + n_dual, n_issue, "retire vs issue");
    endtask

    task automatic test_reset_idle();
        arst_n    = 1'b0;
        thread_en = 4'h0;
        repeat (4) @(posedge clk);
        #2 arst_n = 1'b1;
        repeat (20) begin
            @(negedge clk);
            if (ibus_cyc || dbus_cyc || perf_events != 4'h0) begin
                $display("[ERROR] %0t: bus or events active with no thread enabled", $time);
                err_value++;
            end
        end
    endtask

    task automatic test_alu();
        opcode_t ops [7] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR};
        int n;
        clear_mem();
        put(0, 0, enc(OP_LUI, 1, 0, 0, 16'h8765));
        put(0, 1, enc(OP_ADDI, 1, 1, 0, 16'h4321));
        put(0, 2, enc(OP_LUI, 2, 0, 0, 0));
        put(0, 3, enc(OP_ADDI, 2, 2, 0, 5));
        put(0, 4, enc(OP_LUI, 3, 0, 0, 0));            // Base register
        n = 5;
        for (int i = 0; i < 7; i++) begin
            put(0, n++, enc(ops[i], 4, 1, 2, 0));
            put(0, n++, enc(OP_STORE, 0, 3, 4, 16'h100 + 4 * i));
        end
        put(0, n++, enc(OP_ADDI, 5, 2, 0, 16'hfff9));  // 5 - 7
        put(0, n++, enc(OP_STORE, 0, 3, 1, 16'h140));
        put(0, n++, enc(OP_STORE, 0, 3, 5, 16'h144));
        put(0, n++, enc(OP_HALT, 0, 0, 0, 0));
        run_program(4'b0001, 2000);
        for (int i = 0; i < 7; i++)
            check_word(32'h100 + 4 * i, alu_ref(ops[i], 32'h8765_4321, 32'd5), ops[i].name());
        check_word(32'h140, 32'h8765_4321, "LUI+ADDI");
        check_word(32'h144, 32'hffff_fffe, "ADDI negative");
        check_count(n_retire, n, "retire");
        check_count(wr_log.size(), 9, "write");
    endtask

    task automatic test_loop(int cnt);
        clear_mem();
        put(0, 0, enc(OP_LUI, 1, 0, 0, 0));
        put(0, 1, enc(OP_ADDI, 1, 1, 0, cnt));
        put(0, 2, enc(OP_LUI, 2, 0, 0, 0));
        put(0, 3, enc(OP_LUI, 3, 0, 0, 0));
        put(0, 4, enc(OP_BEQZ, 0, 1, 0, 3));           // Exit to 8
        put(0, 5, enc(OP_ADD, 2, 2, 1, 0));
        put(0, 6, enc(OP_ADDI, 1, 1, 0, 16'hffff));
        put(0, 7, enc(OP_JUMP, 0, 0, 0, 16'hfffc));    // Back to 4
        put(0, 8, enc(OP_STORE, 0, 3, 2, 16'h180));
        put(0, 9, enc(OP_HALT, 0, 0, 0, 0));
        run_program(4'b0001, 4000);
        check_word(32'h180, cnt * (cnt + 1) / 2, "loop sum");
        check_count(n_retire, 4 + 4 * cnt + 3, "retire");
        check_count(n_branch, cnt + 1, "taken branch");
    endtask

    task automatic test_load();
        logic [31:0] pre [3];
        int n;
        clear_mem();
        for (int i = 0; i < 3; i++) begin
            pre[i] = lcg_next();
            dmem[(32'h200 >> 2) + i] = pre[i];
        end
        put(0, 0, enc(OP_LUI, 3, 0, 0, 0));
        put(0, 1, enc(OP_LUI, 5, 0, 0, 0));
        put(0, 2, enc(OP_ADDI, 5, 5, 0, 100));
        n = 3;
        for (int i = 0; i < 3; i++) begin
            put(0, n++, enc(OP_LOAD, 4, 3, 0, 16'h200 + 4 * i));
            put(0, n++, enc(OP_ADD, 4, 4, 5, 0));
            put(0, n++, enc(OP_STORE, 0, 3, 4, 16'h280 + 4 * i));
        end
        put(0, n, enc(OP_HALT, 0, 0, 0, 0));
        run_program(4'b0001, 3000);
        for (int i = 0; i < 3; i++)
            check_word(32'h280 + 4 * i, pre[i] + 32'd100, "load sum");
        check_count(n_io, 6, "I/O access");
    endtask

    task automatic test_threads(logic [3:0] en);
        logic [31:0] pre [4];
        int v;
        clear_mem();
        for (int t = 0; t < 4; t++) begin
            pre[t] = lcg_next();
            dmem[(32'h200 >> 2) + t] = pre[t];
            put(t, 0, enc(OP_LUI, 3, 0, 0, 0));
            put(t, 1, enc(OP_LUI, 1, 0, 0, 0));
            put(t, 2, enc(OP_ADDI, 1, 1, 0, 16 * t + 7));
            for (int k = 0; k < 4; k++) begin
                put(t, 3 + 2 * k, enc(OP_ADDI, 2, 1, 0, k));
                put(t, 4 + 2 * k, enc(OP_STORE, 0, 3, 2, 16'h300 + t * 16'h40 + 4 * k));
            end
            put(t, 11, enc(OP_LOAD, 6, 3, 0, 16'h200 + 4 * t));
            put(t, 12, enc(OP_ADD, 6, 6, 1, 0));
            put(t, 13, enc(OP_STORE, 0, 3, 6, 16'h330 + t * 16'h40));
            put(t, 14, enc(OP_HALT, 0, 0, 0, 0));
        end
        run_program(en, 6000);
        for (int t = 0; t < 4; t++) begin
            v = 16 * t + 7;
            for (int k = 0; k < 4; k++)
                check_word(32'h300 + t * 32'h40 + 4 * k,
                           en[t] ? v + k : 32'hdada_0000 ^ (32'h300 + t * 32'h40 + 4 * k),
                           "thread store");
            check_word(32'h330 + t * 32'h40,
                       en[t] ? pre[t] + v : 32'hdada_0000 ^ (32'h330 + t * 32'h40),
                       "thread load sum");
        end
    endtask

    initial begin
        arst_n    = 1'b0;
        thread_en = 4'h0;
        ibus_ack  = 1'b0;
        ibus_rdat = '0;
        dbus_ack  = 1'b0;
        dbus_rdat = '0;
        lcg_state = 32'd32005;
        rand_wait = 1'b0;
        ibusy     = 0;
        dbusy     = 0;
        err_value = 0;
        err_other = 0;
        clear_mem();

        test_reset_idle();
        test_alu();
        test_loop(5);
        test_load();
        rand_wait = 1'b1;
        test_threads(4'b1111);
        test_threads(4'b1011);                      // Thread 2 held off

        $display("Errors: %0d wrong values, %0d other failures", err_value, err_other);
        if (err_value + err_other == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end
endmodule

//--- core.f
+incdir+.
core_pkg.sv
ifetch_unit.sv
thread_select_stage.sv
operand_fetch_stage.sv
int_execute_stage.sv
io_request_queue.sv
core.sv
core_properties.sv
core_tb.sv

//--- run.sh
#!/bin/sh
# Build the core testbench with Verilator, run it, and scan the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module core_tb -f core.f -o core_sim
./obj_dir/core_sim > sim.log 2>&1
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
exit 0
